//--- hdl/graph_cu_pkg.sv
// Field widths and record types for the edge-update compute unit
package graph_cu_pkg;

	localparam int VERTEX_ID_W  = 16;
	localparam int EDGE_COUNT_W = 16;
	localparam int EDGE_DATA_W  = 8;
	localparam int COUNTER_W    = 32;
	localparam int CU_COORD_W   = 4;

	typedef logic [VERTEX_ID_W-1:0]  vertex_id_t;
	typedef logic [EDGE_COUNT_W-1:0] edge_count_t;
	typedef logic [EDGE_DATA_W-1:0]  edge_data_t;
	typedef logic [COUNTER_W-1:0]    counter_t;
	typedef logic [CU_COORD_W-1:0]   cu_coord_t;

	// Vertex job from the dispatcher
	typedef struct packed {
		vertex_id_t  id;
		edge_count_t edge_count;
	} vertex_job_payload_t;

	typedef struct packed {
		logic                valid;
		vertex_job_payload_t payload;
	} vertex_job_t;

	// Edge record from the edge buffer
	typedef struct packed {
		vertex_id_t src;
		vertex_id_t dest;
		edge_data_t data;
	} edge_rec_payload_t;

	typedef struct packed {
		logic              valid;
		edge_rec_payload_t payload;
	} edge_rec_t;

	// Update record sent on the write bus
	typedef struct packed {
		vertex_id_t index;
		cu_coord_t  cu_x;
		cu_coord_t  cu_y;
		logic       flag;
		vertex_id_t dest;
	} edge_update_payload_t;

	typedef struct packed {
		logic                 valid;
		edge_update_payload_t payload;
	} edge_update_t;

	// Write response echoes the update index
	typedef struct packed {
		logic       valid;
		vertex_id_t index;
	} write_resp_t;

	typedef struct packed {
		logic full;
		logic alfull;
		logic empty;
	} queue_status_t;

endpackage

//--- hdl/sync_fifo.sv
// Synchronous first-word-fall-through FIFO with full, almost-full and empty flags
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 8
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             alfull,
	output logic             empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CW-1:0]    count;
	logic             do_push;
	logic             do_pop;

	// Wrap at DEPTH, which need not be a power of two
	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
		return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_push  = push && !full;
	assign do_pop   = pop && !empty;
	assign data_out = mem[rd_ptr];
	assign full     = (count == CW'(DEPTH));
	// Two entries of slack for data already in flight
	assign alfull   = (count >= CW'(DEPTH - 2));
	assign empty    = (count == '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

endmodule

//--- hdl/vertex_job_decode.sv
// Input registering, enable register, job latch and edge countdown
`timescale 1ns/1ps

module vertex_job_decode (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enable,
	input  graph_cu_pkg::vertex_job_t   vertex_job,
	input  graph_cu_pkg::edge_rec_t     edge_in,
	input  logic                        count_dec,
	input  logic                        finish_hold,
	input  graph_cu_pkg::queue_status_t queue_status,
	output logic                        enabled,
	output graph_cu_pkg::vertex_job_t   job_cur,
	output graph_cu_pkg::edge_rec_t     edge_reg,
	output logic                        countdown_zero,
	output logic                        job_ready,
	output logic                        edge_request
);

	logic                              job_valid_q;
	graph_cu_pkg::vertex_job_payload_t job_payload_q;
	logic                              edge_valid_q;
	graph_cu_pkg::edge_rec_payload_t   edge_payload_q;
	graph_cu_pkg::edge_count_t         countdown;
	logic                              accept;

	assign accept         = enabled && job_ready && vertex_job.valid;
	assign countdown_zero = (countdown == '0);
	assign job_cur        = '{valid: job_valid_q, payload: job_payload_q};
	assign edge_reg       = '{valid: edge_valid_q, payload: edge_payload_q};

	//////////////////////////////
	// Control registers
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled      <= 1'b0;
			job_valid_q  <= 1'b0;
			edge_valid_q <= 1'b0;
			countdown    <= '0;
			job_ready    <= 1'b0;
			edge_request <= 1'b0;
		end else begin
			enabled <= enable;
			if (enabled) begin
				edge_valid_q <= edge_in.valid;
				if (accept) begin
					job_valid_q <= 1'b1;
					countdown   <= vertex_job.payload.edge_count;
				end else begin
					// Job retires once execute starts its hold
					if (finish_hold)
						job_valid_q <= 1'b0;
					if (count_dec && !countdown_zero)
						countdown <= countdown - 1'b1;
				end
				job_ready    <= !accept && !job_valid_q && !finish_hold;
				// Stop fetching early so queued updates always fit
				edge_request <= job_valid_q && !finish_hold && !queue_status.alfull;
			end
		end
	end

	// Payload registers
	always_ff @(posedge clock) begin
		if (enabled)
			edge_payload_q <= edge_in.payload;
		if (accept)
			job_payload_q <= vertex_job.payload;
	end

	// Dispatcher must respect job_ready
	assert property (@(posedge clock) disable iff (!rstn)
		vertex_job.valid |-> job_ready);

endmodule

//--- hdl/edge_match_execute.sv
// Edge compare against the current job, update build and finish hold register
`timescale 1ns/1ps

module edge_match_execute #(
	parameter int CU_ID_X     = 1,
	parameter int CU_ID_Y     = 1,
	parameter int FINISH_HOLD = 5
) (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  graph_cu_pkg::vertex_job_t   job_cur,
	input  graph_cu_pkg::edge_rec_t     edge_reg,
	input  logic                        countdown_zero,
	output logic                        count_dec,
	output logic                        finish_hold,
	output graph_cu_pkg::edge_update_t  upd,
	output logic                        finish_no_update
);

	logic                               live;
	logic                               match;
	logic                               data_nz;
	logic                               hit;
	logic                               finish_start;
	logic [FINISH_HOLD-1:0]             hold;
	logic                               upd_valid_q;
	graph_cu_pkg::edge_update_payload_t upd_payload_q;
	logic                               job_updated;

	//////////////////////////////
	// Match logic
	//////////////////////////////

	// No edge counts once the job has finished
	assign live    = enabled && job_cur.valid && !finish_hold;
	assign match   = edge_reg.valid && (edge_reg.payload.src == job_cur.payload.id);
	assign data_nz = |edge_reg.payload.data;
	assign hit     = live && match && data_nz;

	// Zero-data edge of this vertex uses up one count
	assign count_dec = live && match && !data_nz;

	// An update wins over an exhausted count in the same cycle
	assign finish_start = hit || (live && countdown_zero);
	assign finish_hold  = |hold;

	assign upd = '{valid: upd_valid_q, payload: upd_payload_q};

	//////////////////////////////
	// Update and finish hold
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			upd_valid_q      <= 1'b0;
			finish_no_update <= 1'b0;
			hold             <= '0;
		end else if (enabled) begin
			upd_valid_q      <= hit;
			finish_no_update <= live && countdown_zero && !hit;
			// Shift a single finish marker through FINISH_HOLD stages
			hold             <= (hold << 1) | FINISH_HOLD'(finish_start);
		end else begin
			upd_valid_q      <= 1'b0;
			finish_no_update <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (hit) begin
			upd_payload_q.index <= job_cur.payload.id;
			upd_payload_q.cu_x  <= graph_cu_pkg::cu_coord_t'(CU_ID_X);
			upd_payload_q.cu_y  <= graph_cu_pkg::cu_coord_t'(CU_ID_Y);
			upd_payload_q.flag  <= 1'b1;
			upd_payload_q.dest  <= edge_reg.payload.dest;
		end
	end

	// Remembers an update already sent for the current job
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			job_updated <= 1'b0;
		else if (!job_cur.valid)
			job_updated <= 1'b0;
		else if (upd_valid_q)
			job_updated <= 1'b1;
	end

	// A job produces at most one update
	assert property (@(posedge clock) disable iff (!rstn)
		upd_valid_q |-> !job_updated);

endmodule

//--- hdl/update_write_result.sv
// Update queue, write bus request and grant, response and vertex counters
`timescale 1ns/1ps

module update_write_result #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  graph_cu_pkg::edge_update_t  upd,
	input  logic                        finish_no_update,
	input  logic                        write_grant,
	input  logic                        bus_alfull,
	input  graph_cu_pkg::write_resp_t   write_resp,
	output logic                        write_request,
	output graph_cu_pkg::edge_update_t  write_out,
	output graph_cu_pkg::queue_status_t queue_status,
	output graph_cu_pkg::counter_t      resp_count,
	output graph_cu_pkg::counter_t      vertices_done
);

	localparam int PAYLOAD_W = $bits(graph_cu_pkg::edge_update_payload_t);

	logic                 q_full;
	logic                 q_alfull;
	logic                 q_empty;
	logic [PAYLOAD_W-1:0] head;
	logic                 grant_q;
	logic                 pop;
	logic                 resp_seen;

	assign queue_status = '{full: q_full, alfull: q_alfull, empty: q_empty};

	//////////////////////////////
	// Write bus side
	//////////////////////////////

	assign write_request = enabled && !q_empty && !bus_alfull;

	// Grant is acted on next cycle, and only if the bus still has room
	assign pop       = enabled && grant_q && !bus_alfull && !q_empty;
	assign write_out = '{valid: pop, payload: graph_cu_pkg::edge_update_payload_t'(head)};

	sync_fifo #(
		.WIDTH(PAYLOAD_W),
		.DEPTH(QUEUE_DEPTH)
	) update_queue_i (
		.clock   (clock),
		.rstn    (rstn),
		.push    (upd.valid),
		.data_in (upd.payload),
		.pop     (pop),
		.data_out(head),
		.full    (q_full),
		.alfull  (q_alfull),
		.empty   (q_empty)
	);

	//////////////////////////////
	// Grant latch and counters
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			grant_q       <= 1'b0;
			resp_seen     <= 1'b0;
			resp_count    <= '0;
			vertices_done <= '0;
		end else begin
			if (enabled) begin
				grant_q   <= write_grant && !bus_alfull;
				resp_seen <= write_resp.valid;
			end else begin
				resp_seen <= 1'b0;
			end
			resp_count    <= resp_count + graph_cu_pkg::counter_t'(resp_seen);
			// A response and a no-update finish may land together
			vertices_done <= vertices_done + graph_cu_pkg::counter_t'(resp_seen)
			                 + graph_cu_pkg::counter_t'(finish_no_update);
		end
	end

	// Edge fetch throttling upstream must keep the queue from overflowing
	assert property (@(posedge clock) disable iff (!rstn)
		upd.valid |-> !q_full);

endmodule

//--- hdl/edge_update_cu.sv
// Edge-update compute unit top level with decode, execute and result stages
`timescale 1ns/1ps

module edge_update_cu #(
	parameter int CU_ID_X     = 1,
	parameter int CU_ID_Y     = 1,
	parameter int FINISH_HOLD = 5,
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enable,
	input  graph_cu_pkg::vertex_job_t  vertex_job,
	input  graph_cu_pkg::edge_rec_t    edge_in,
	input  logic                       write_grant,
	input  logic                       bus_alfull,
	input  graph_cu_pkg::write_resp_t  write_resp,
	output logic                       job_ready,
	output logic                       edge_request,
	output logic                       write_request,
	output graph_cu_pkg::edge_update_t write_out,
	output graph_cu_pkg::counter_t     resp_count,
	output graph_cu_pkg::counter_t     vertices_done
);

	logic                        enabled;
	graph_cu_pkg::vertex_job_t   job_cur;
	graph_cu_pkg::edge_rec_t     edge_reg;
	logic                        countdown_zero;
	logic                        count_dec;
	logic                        finish_hold;
	graph_cu_pkg::edge_update_t  upd;
	logic                        finish_no_update;
	graph_cu_pkg::queue_status_t queue_status;

	vertex_job_decode decode_i (
		.clock         (clock),
		.rstn          (rstn),
		.enable        (enable),
		.vertex_job    (vertex_job),
		.edge_in       (edge_in),
		.count_dec     (count_dec),
		.finish_hold   (finish_hold),
		.queue_status  (queue_status),
		.enabled       (enabled),
		.job_cur       (job_cur),
		.edge_reg      (edge_reg),
		.countdown_zero(countdown_zero),
		.job_ready     (job_ready),
		.edge_request  (edge_request)
	);

	edge_match_execute #(
		.CU_ID_X    (CU_ID_X),
		.CU_ID_Y    (CU_ID_Y),
		.FINISH_HOLD(FINISH_HOLD)
	) execute_i (
		.clock           (clock),
		.rstn            (rstn),
		.enabled         (enabled),
		.job_cur         (job_cur),
		.edge_reg        (edge_reg),
		.countdown_zero  (countdown_zero),
		.count_dec       (count_dec),
		.finish_hold     (finish_hold),
		.upd             (upd),
		.finish_no_update(finish_no_update)
	);

	update_write_result #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) result_i (
		.clock           (clock),
		.rstn            (rstn),
		.enabled         (enabled),
		.upd             (upd),
		.finish_no_update(finish_no_update),
		.write_grant     (write_grant),
		.bus_alfull      (bus_alfull),
		.write_resp      (write_resp),
		.write_request   (write_request),
		.write_out       (write_out),
		.queue_status    (queue_status),
		.resp_count      (resp_count),
		.vertices_done   (vertices_done)
	);

endmodule

//--- tests/edge_update_cu_tb.sv
// Testbench for the edge-update unit with job, edge, bus and response models and checks
`timescale 1ns/1ps

module edge_update_cu_tb;

	localparam int CU_ID_X        = 3;
	localparam int CU_ID_Y        = 5;
	localparam int FINISH_HOLD    = 5;
	localparam int QUEUE_DEPTH    = 8;
	localparam int NUM_JOBS       = 40;
	localparam int RESET_CYCLES   = 16;
	localparam int DISABLE_CYCLES = 8;
	localparam int SEED           = 30507;
	localparam int TIMEOUT_CYCLES = NUM_JOBS * 200 + RESET_CYCLES + DISABLE_CYCLES;

	logic                              clock;
	logic                              rstn;
	logic                              enable;
	graph_cu_pkg::vertex_job_t         vertex_job;
	graph_cu_pkg::edge_rec_t           edge_in;
	logic                              write_grant;
	logic                              bus_alfull;
	graph_cu_pkg::write_resp_t         write_resp;
	logic                              job_ready;
	logic                              edge_request;
	logic                              write_request;
	graph_cu_pkg::edge_update_t        write_out;
	graph_cu_pkg::counter_t            resp_count;
	graph_cu_pkg::counter_t            vertices_done;

	// Reference model state
	graph_cu_pkg::edge_update_payload_t exp_q[$];
	int                                 resp_due[$];
	graph_cu_pkg::vertex_id_t           resp_index[$];
	int                                 cycle;
	int                                 last_due;
	int                                 resp_sent;
	logic                               grant_clean;
	graph_cu_pkg::edge_update_payload_t exp_upd;
	int                                 due;

	edge_update_cu #(
		.CU_ID_X    (CU_ID_X),
		.CU_ID_Y    (CU_ID_Y),
		.FINISH_HOLD(FINISH_HOLD),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) dut_i (
		.clock        (clock),
		.rstn         (rstn),
		.enable       (enable),
		.vertex_job   (vertex_job),
		.edge_in      (edge_in),
		.write_grant  (write_grant),
		.bus_alfull   (bus_alfull),
		.write_resp   (write_resp),
		.job_ready    (job_ready),
		.edge_request (edge_request),
		.write_request(write_request),
		.write_out    (write_out),
		.resp_count   (resp_count),
		.vertices_done(vertices_done)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial cycle = 0;
	always @(posedge clock)
		cycle <= cycle + 1;

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			$display("** Error %s expected 0x%0h got 0x%0h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_outputs_idle();
		check_value("job_ready", 0, job_ready);
		check_value("edge_request", 0, edge_request);
		check_value("write_request", 0, write_request);
		check_value("write_out.valid", 0, write_out.valid);
		check_value("resp_count", 0, resp_count);
		check_value("vertices_done", 0, vertices_done);
	endtask

	//////////////////////////////
	// Job and edge stimulus
	//////////////////////////////

	task automatic run_job();
		graph_cu_pkg::vertex_id_t           id;
		graph_cu_pkg::edge_count_t          count;
		graph_cu_pkg::edge_rec_payload_t    rec;
		graph_cu_pkg::edge_rec_payload_t    edges[$];
		graph_cu_pkg::edge_update_payload_t upd;
		int                                 left;
		bit                                 done;
		bit                                 req;
		int                                 i;
		id    = graph_cu_pkg::vertex_id_t'($urandom);
		count = graph_cu_pkg::edge_count_t'(1 + $urandom % 6);
		left  = int'(count);
		done  = 1'b0;
		// First own edge with nonzero data wins and each zero-data own edge uses one count
		while (!done) begin
			rec.dest = graph_cu_pkg::vertex_id_t'($urandom);
			rec.data = graph_cu_pkg::edge_data_t'($urandom);
			if ($urandom % 3 == 0) begin
				rec.src = id + graph_cu_pkg::vertex_id_t'(1 + $urandom % 1000);
			end else begin
				rec.src = id;
				if ($urandom % 4 == 0) begin
					rec.data   = graph_cu_pkg::edge_data_t'(1 + $urandom % 255);
					upd.index  = id;
					upd.cu_x   = graph_cu_pkg::cu_coord_t'(CU_ID_X);
					upd.cu_y   = graph_cu_pkg::cu_coord_t'(CU_ID_Y);
					upd.flag   = 1'b1;
					upd.dest   = rec.dest;
					exp_q.push_back(upd);
					done = 1'b1;
				end else begin
					rec.data = '0;
					left--;
					done = (left == 0);
				end
			end
			edges.push_back(rec);
		end
		while (!job_ready)
			@(negedge clock);
		@(posedge clock);
		#1;
		vertex_job = '{valid: 1'b1, payload: '{id: id, edge_count: count}};
		@(posedge clock);
		#1;
		vertex_job = '0;
		i = 0;
		while (i < edges.size()) begin
			@(negedge clock);
			req = edge_request;
			@(posedge clock);
			#1;
			if (req) begin
				edge_in = '{valid: 1'b1, payload: edges[i]};
				i++;
			end else begin
				edge_in = '0;
			end
		end
		@(posedge clock);
		#1;
		edge_in = '0;
	endtask

	initial begin
		void'($urandom(SEED));
		rstn       = 1'b0;
		enable     = 1'b0;
		vertex_job = '0;
		edge_in    = '0;
		resp_sent  = 0;
		repeat (RESET_CYCLES) begin
			@(negedge clock);
			check_outputs_idle();
		end
		@(posedge clock);
		#1;
		rstn = 1'b1;
		// Out of reset but still disabled
		repeat (DISABLE_CYCLES) begin
			@(negedge clock);
			check_outputs_idle();
		end
		@(posedge clock);
		#1;
		enable = 1'b1;
		repeat (NUM_JOBS)
			run_job();
		while (vertices_done < graph_cu_pkg::counter_t'(NUM_JOBS))
			@(negedge clock);
		repeat (4) @(negedge clock);
		check_value("vertices_done", NUM_JOBS, vertices_done);
		check_value("resp_count", resp_sent, resp_count);
		check_value("expected updates left", 0, exp_q.size());
		$display("Test OK");
		$finish;
	end

	//////////////////////////////
	// Bus and response models
	//////////////////////////////

	initial begin
		write_grant = 1'b0;
		@(posedge rstn);
		forever begin
			@(negedge clock);
			if (write_request) begin
				repeat ($urandom % 4) @(posedge clock);
				@(posedge clock);
				#1;
				write_grant = 1'b1;
				@(posedge clock);
				#1;
				write_grant = 1'b0;
			end
		end
	end

	// Bursts of bus back-pressure
	initial begin
		bus_alfull = 1'b0;
		@(posedge rstn);
		forever begin
			repeat (10 + $urandom % 40) @(posedge clock);
			#1;
			bus_alfull = 1'b1;
			repeat (5 + $urandom % 30) @(posedge clock);
			#1;
			bus_alfull = 1'b0;
		end
	end

	initial begin
		write_resp = '0;
		@(posedge rstn);
		forever begin
			@(posedge clock);
			#1;
			if (resp_due.size() > 0 && cycle >= resp_due[0]) begin
				void'(resp_due.pop_front());
				write_resp = '{valid: 1'b1, index: resp_index.pop_front()};
				resp_sent++;
			end else begin
				write_resp = '0;
			end
		end
	end

	// Write monitor compares against the model and schedules responses
	initial begin
		grant_clean = 1'b0;
		last_due    = 0;
		@(posedge rstn);
		forever begin
			@(negedge clock);
			// Bus back-pressure holds off requests
			if (bus_alfull)
				check_value("write_request", 0, write_request);
			if (write_out.valid) begin
				check_value("bus_alfull", 0, bus_alfull);
				check_value("clean grant before write_out", 1, grant_clean);
				if (exp_q.size() == 0)
					check_value("write_out.valid", 0, write_out.valid);
				exp_upd = exp_q.pop_front();
				check_value("write_out.payload", exp_upd, write_out.payload);
				due = cycle + 2 + $urandom % 9;
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				resp_due.push_back(due);
				resp_index.push_back(write_out.payload.index);
			end
			grant_clean = write_grant && !bus_alfull;
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clock);
		$display("Run timed out before all jobs were retired");
		$display("Test FAILED");
		$fatal(1);
	end

endmodule

//--- all.f
hdl/graph_cu_pkg.sv
hdl/sync_fifo.sv
hdl/vertex_job_decode.sv
hdl/edge_match_execute.sv
hdl/update_write_result.sv
hdl/edge_update_cu.sv
tests/edge_update_cu_tb.sv

//--- Makefile
TOP = edge_update_cu_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f all.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" sim.log; then echo "No pass message in log"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
